/* build.f */
src/nco_pkg.sv
src/track_pkg.sv
src/nco.sv
src/correlator.sv
src/dump_ctl.sv
src/run_length_estimator.sv
src/quad_tracker_top.sv
dv/quad_tracker_assertions.sv
dv/tb_quad_tracker.sv

/* dv/quad_tracker_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module quad_tracker_assertions #(
    parameter int WINDOW = 64
) (
    input wire clk,
    input wire rst_in,
    input wire i_corr_valid,
    input wire i_est_valid
);

    logic       seen;
    logic [7:0] gap;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            seen <= 1'b0;
            gap  <= '0;
        end else if (i_corr_valid) begin
            seen <= 1'b1;
            gap  <= '0; // Counts clocks since the last correlation pulse.
        end else if (gap != 8'hff) begin
            gap <= gap + 8'd1;
        end
    end

    corr_period: assert property (@(posedge clk) disable iff (rst_in)
        seen |-> (i_corr_valid == (gap == 8'(WINDOW - 1))))
        else $error("o_corr_valid does not recur every WINDOW clocks");

    est_single: assert property (@(posedge clk) disable iff (rst_in)
        i_est_valid |=> !i_est_valid)
        else $error("o_est_valid is high for two clocks in a row");

    reset_quiet: assert property (@(posedge clk)
        (rst_in && $past(rst_in)) |-> (!i_corr_valid && !i_est_valid))
        else $error("a valid signal is high during reset");

endmodule

bind quad_tracker_top quad_tracker_assertions #(.WINDOW(WINDOW)) u_assertions (
    .clk          (clk),
    .rst_in       (rst_in),
    .i_corr_valid (o_corr_valid),
    .i_est_valid  (o_est_valid)
);

`default_nettype wire

/* dv/tb_quad_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_quad_tracker;

    localparam int WINDOW       = 16;
    localparam int EST_LOG2     = 3;
    localparam int EST_TURNS    = 1 << EST_LOG2;
    localparam int CORR_TIMEOUT = 2 * WINDOW + 4;
    localparam int EST_TIMEOUT  = 12000;
    localparam nco_pkg::freq_word_t TONE_FREQ = 16'h1000; // One tone period per window.

    logic                  clk;
    logic                  rst_in;
    logic                  i_sig;
    nco_pkg::freq_word_t   i_freq;
    track_pkg::corr_pair_t o_corr;
    logic                  o_corr_valid;
    track_pkg::est_t       o_est;
    logic                  o_est_valid;

    logic [31:0]           lfsr_state;
    nco_pkg::phase_t       tone_phase;
    nco_pkg::freq_word_t   next_freq;
    logic                  force_code;
    int                    edges;
    logic                  seen_corr;

    nco_pkg::phase_t       m_phase_i;
    nco_pkg::phase_t       m_phase_q;
    int                    m_cycle;
    int                    m_acc_i;
    int                    m_acc_q;
    track_pkg::corr_pair_t m_corr;
    logic                  m_corr_valid;
    logic                  m_pend;
    logic [1:0]            m_sign_new;
    logic [1:0]            m_sign_prev;
    int                    m_run_i;
    int                    m_run_q;
    logic                  m_turn_q;
    int                    m_sum;
    int                    m_turns;
    track_pkg::est_t       m_est;
    logic                  m_est_valid;

    quad_tracker_top #(.WINDOW(WINDOW), .EST_LOG2(EST_LOG2)) u_dut (
        .clk          (clk),
        .rst_in       (rst_in),
        .i_sig        (i_sig),
        .i_freq       (i_freq),
        .o_corr       (o_corr),
        .o_corr_valid (o_corr_valid),
        .o_est        (o_est),
        .o_est_valid  (o_est_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int saturate(input int v);
        if (v > 127) return 127;
        if (v < -128) return -128;
        return v;
    endfunction

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Stopping at the first failure.");
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic check_corr(input track_pkg::corr_pair_t got,
                              input track_pkg::corr_pair_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("o_corr is i=%0d q=%0d, expected i=%0d q=%0d",
                                      got.i, got.q, exp.i, exp.q));
        end
    endtask

    task automatic check_est(input track_pkg::est_t got, input track_pkg::est_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("o_est is %0d, expected %0d", got, exp));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // One clock of the reference model, using the inputs seen at this edge.
    task automatic model_step();
        logic ch_i;
        logic ch_q;
        logic dump;
        if (rst_in) begin
            m_phase_i    = '0;
            m_phase_q    = nco_pkg::QUAD_OFFSET;
            m_cycle      = 0;
            m_acc_i      = 0;
            m_acc_q      = 0;
            m_corr       = '0;
            m_corr_valid = 1'b0;
            m_pend       = 1'b0;
            m_sign_new   = '0;
            m_sign_prev  = '0;
            m_run_i      = 0;
            m_run_q      = 0;
            m_turn_q     = 1'b0;
            m_sum        = 0;
            m_turns      = 0;
            m_est        = '0;
            m_est_valid  = 1'b0;
        end else begin
            ch_i = m_sign_new[1] != m_sign_prev[1];
            ch_q = m_sign_new[0] != m_sign_prev[0];
            if (m_turns == EST_TURNS) begin
                m_est       = track_pkg::est_t'(m_sum >> EST_LOG2);
                m_est_valid = 1'b1;
                m_sum       = 0;
                m_turns     = 0;
            end else begin
                m_est_valid = 1'b0;
                if (m_pend && ch_q && m_turn_q) begin
                    m_sum    = m_sum + m_run_q;
                    m_turn_q = 1'b0;
                end else if (m_pend && ch_i && !m_turn_q) begin
                    m_sum    = m_sum + m_run_i;
                    m_turn_q = 1'b1;
                    m_turns++;
                end
            end
            if (m_pend) begin
                m_sign_prev = m_sign_new;
                m_run_i     = ch_i ? 1 : ((m_run_i < 255) ? m_run_i + 1 : 255);
                m_run_q     = ch_q ? 1 : ((m_run_q < 255) ? m_run_q + 1 : 255);
            end
            if (m_corr_valid) begin
                m_sign_new = {m_corr.i[7], m_corr.q[7]};
            end
            m_pend = m_corr_valid;
            dump = (m_cycle > 0) && (m_cycle % WINDOW == 0); // Cycle 0 is the idle clock.
            m_acc_i = saturate(m_acc_i + ((i_sig == m_phase_i[15]) ? 1 : -1));
            m_acc_q = saturate(m_acc_q + ((i_sig == m_phase_q[15]) ? 1 : -1));
            m_corr_valid = dump;
            if (dump) begin
                m_corr.i = track_pkg::corr_t'(m_acc_i);
                m_corr.q = track_pkg::corr_t'(m_acc_q);
                m_acc_i  = 0;
                m_acc_q  = 0;
            end
            m_cycle++;
            m_phase_i = m_phase_i + i_freq;
            m_phase_q = m_phase_q + i_freq;
        end
    endtask

    task automatic check_outputs();
        check_valid(o_corr_valid, m_corr_valid, "o_corr_valid");
        check_valid(o_est_valid, m_est_valid, "o_est_valid");
        check_corr(o_corr, m_corr);
        check_est(o_est, m_est);
        if (o_corr_valid && !seen_corr) begin
            seen_corr = 1'b1;
            if (edges != WINDOW + 2) begin
                report_mismatch($sformatf("first o_corr_valid %0d clocks after release, expected %0d",
                                          edges, WINDOW + 2));
            end
        end
    endtask

    task automatic clock_cycle(input logic next_rst);
        logic [2:0] noise;
        @(posedge clk);
        model_step();
        if (rst_in && !next_rst) begin
            edges     = 1;
            seen_corr = 1'b0;
        end else begin
            edges++;
        end
        tone_phase = tone_phase + TONE_FREQ;
        rst_in <= next_rst;
        i_freq <= next_freq;
        if (force_code) begin
            i_sig <= m_phase_i[15]; // Model phase for the coming cycle.
        end else begin
            noise = 3'(draw_bits(3));
            i_sig <= tone_phase[15] ^ (&noise); // Flips about one sample in eight.
        end
        @(negedge clk);
        check_outputs();
    endtask

    task automatic wait_pulse(input logic want_est, input int limit);
        int n;
        n = 0;
        clock_cycle(1'b0);
        while (!(want_est ? o_est_valid : o_corr_valid)) begin
            if (n >= limit) begin
                $display("Timeout after %0d clocks waiting for %s.", limit,
                         want_est ? "o_est_valid" : "o_corr_valid");
                stop_on_failure();
            end
            clock_cycle(1'b0);
            n++;
        end
    endtask

    task automatic run_phase(input nco_pkg::freq_word_t freq, input logic forced,
                             input int n_corr, input int n_est,
                             output track_pkg::est_t last_est);
        last_est   = '0;
        force_code = forced;
        next_freq  = freq;
        repeat (16) clock_cycle(1'b1);
        repeat (n_corr) wait_pulse(1'b0, CORR_TIMEOUT);
        repeat (n_est) begin
            wait_pulse(1'b1, EST_TIMEOUT);
            last_est = o_est;
        end
        $display("Phase with i_freq %h done, last estimate %0d.", freq, last_est);
    endtask

    initial begin
        track_pkg::est_t est_near;
        track_pkg::est_t est_far;
        track_pkg::est_t est_forced;
        rst_in     = 1'b1;
        i_sig      = 1'b0;
        i_freq     = '0;
        next_freq  = '0;
        force_code = 1'b0;
        lfsr_state = 32'h50f867dc;
        tone_phase = '0;
        edges      = 0;
        seen_corr  = 1'b0;

        run_phase(TONE_FREQ + 16'd64 + 16'(draw_bits(6)), 1'b0, 3, 2, est_near);
        run_phase(16'h5800 + 16'(draw_bits(10)), 1'b0, 3, 2, est_far);
        run_phase(16'(draw_bits(16)), 1'b1, 6, 0, est_forced);

        if (est_near == est_far) begin
            report_mismatch($sformatf("near and far estimates are both %0d", est_near));
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the quad tracker testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module tb_quad_tracker \
    -f build.f \
    -o sim_tb_quad_tracker

# A failing run exits non-zero, so the log carries the verdict.
./obj_dir/sim_tb_quad_tracker > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported a failure."
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "Simulation ended without a verdict."
    exit 1
fi
echo "Simulation finished cleanly."

/* src/correlator.sv */
`timescale 1ns/100ps
`default_nettype none

module correlator (
    input  wire                clk,
    input  wire                rst_in,
    input  wire                i_sig,
    input  wire                i_code,
    input  wire                i_dump,
    output track_pkg::corr_t   o_value,
    output logic               o_valid
);

    track_pkg::corr_t acc;
    track_pkg::corr_t acc_next;

    // Match counts up and mismatch counts down, both clamped to the corr_t range.
    always_comb begin
        acc_next = acc;
        if (i_sig == i_code) begin
            if (acc != track_pkg::CORR_MAX) begin
                acc_next = acc + 8'sd1;
            end
        end else if (acc != track_pkg::CORR_MIN) begin
            acc_next = acc - 8'sd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            acc     <= '0;
            o_value <= '0;
            o_valid <= 1'b0;
        end else if (i_dump) begin
            o_value <= acc_next; // Last sample of the window is included.
            o_valid <= 1'b1;
            acc     <= '0;
        end else begin
            acc     <= acc_next;
            o_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/dump_ctl.sv */
`timescale 1ns/100ps
`default_nettype none

module dump_ctl #(
    parameter int WINDOW = 64
) (
    input  wire  clk,
    input  wire  rst_in,
    output logic o_dump
);

    localparam logic [7:0] LAST = 8'(WINDOW - 1);

    track_pkg::dump_state_t state;
    logic [7:0]             cnt;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            state <= track_pkg::ST_CLEAR;
            cnt   <= '0;
        end else begin
            case (state)
                track_pkg::ST_CLEAR: begin
                    state <= track_pkg::ST_INTEGRATE; // One idle clock before the first window.
                    cnt   <= '0;
                end
                track_pkg::ST_INTEGRATE: begin
                    if (cnt == LAST) begin
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                default: begin
                    state <= track_pkg::ST_CLEAR;
                    cnt   <= '0;
                end
            endcase
        end
    end

    // Strobe on the final clock of each window.
    assign o_dump = (state == track_pkg::ST_INTEGRATE) && (cnt == LAST);

endmodule

`default_nettype wire

/* src/nco.sv */
`timescale 1ns/100ps
`default_nettype none

module nco #(
    parameter nco_pkg::phase_t INIT_PHASE = '0
) (
    input  wire                 clk,
    input  wire                 rst_in,
    input  nco_pkg::freq_word_t i_freq,
    output logic                o_code
);

    localparam int MSB = $bits(nco_pkg::phase_t) - 1;

    nco_pkg::phase_t phase;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            phase <= INIT_PHASE;
        end else begin
            phase <= phase + i_freq; // Wraps once per output period.
        end
    end

    // The code is taken from the phase before this cycle's step.
    assign o_code = phase[MSB];

endmodule

`default_nettype wire

/* src/nco_pkg.sv */
`default_nettype none

package nco_pkg;

    // Oscillator phase. The top bit is the reference code.
    typedef logic [15:0] phase_t;

    // Phase step added on every clock.
    typedef logic [15:0] freq_word_t;

    // Quarter turn, used as the reset phase of the Q oscillator.
    localparam phase_t QUAD_OFFSET = 16'h4000;

endpackage

`default_nettype wire

/* src/quad_tracker_top.sv */
`timescale 1ns/100ps
`default_nettype none

module quad_tracker_top #(
    parameter int WINDOW   = 64,
    parameter int EST_LOG2 = 12
) (
    input  wire                    clk,
    input  wire                    rst_in,
    input  wire                    i_sig,
    input  nco_pkg::freq_word_t    i_freq,
    output track_pkg::corr_pair_t  o_corr,
    output logic                   o_corr_valid,
    output track_pkg::est_t        o_est,
    output logic                   o_est_valid
);

    logic code_i;
    logic code_q;
    logic dump_stb;

    nco #(.INIT_PHASE('0)) u_nco_i (
        .clk    (clk),
        .rst_in (rst_in),
        .i_freq (i_freq),
        .o_code (code_i)
    );

    // Q reference leads I by a quarter turn.
    nco #(.INIT_PHASE(nco_pkg::QUAD_OFFSET)) u_nco_q (
        .clk    (clk),
        .rst_in (rst_in),
        .i_freq (i_freq),
        .o_code (code_q)
    );

    correlator u_corr_i (
        .clk     (clk),
        .rst_in  (rst_in),
        .i_sig   (i_sig),
        .i_code  (code_i),
        .i_dump  (dump_stb),
        .o_value (o_corr.i),
        .o_valid (o_corr_valid)
    );

    // Shares the dump strobe, so its valid matches the I correlator.
    correlator u_corr_q (
        .clk     (clk),
        .rst_in  (rst_in),
        .i_sig   (i_sig),
        .i_code  (code_q),
        .i_dump  (dump_stb),
        .o_value (o_corr.q),
        .o_valid ()
    );

    dump_ctl #(.WINDOW(WINDOW)) u_dump_ctl (
        .clk    (clk),
        .rst_in (rst_in),
        .o_dump (dump_stb)
    );

    run_length_estimator #(.EST_LOG2(EST_LOG2)) u_estimator (
        .clk     (clk),
        .rst_in  (rst_in),
        .i_corr  (o_corr),
        .i_valid (o_corr_valid),
        .o_est   (o_est),
        .o_valid (o_est_valid)
    );

endmodule

`default_nettype wire

/* src/run_length_estimator.sv */
`timescale 1ns/100ps
`default_nettype none

module run_length_estimator #(
    parameter int EST_LOG2 = 12
) (
    input  wire                    clk,
    input  wire                    rst_in,
    input  track_pkg::corr_pair_t  i_corr,
    input  wire                    i_valid,
    output track_pkg::est_t        o_est,
    output logic                   o_valid
);

    localparam int ACC_W = 8 + EST_LOG2;
    localparam logic [EST_LOG2:0] TURNS_PER_EST = {1'b1, {EST_LOG2{1'b0}}};

    logic               sign_i_new;
    logic               sign_q_new;
    logic               sign_i_prev;
    logic               sign_q_prev;
    logic               pend;
    logic               turn_q;
    logic               i_changed;
    logic               q_changed;
    track_pkg::run_t    run_i;
    track_pkg::run_t    run_q;
    logic [ACC_W-1:0]   sum;
    logic [EST_LOG2:0]  turns;

    assign i_changed = sign_i_new != sign_i_prev;
    assign q_changed = sign_q_new != sign_q_prev;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            sign_i_new  <= 1'b0;
            sign_q_new  <= 1'b0;
            sign_i_prev <= 1'b0;
            sign_q_prev <= 1'b0;
            pend        <= 1'b0;
            run_i       <= '0;
            run_q       <= '0;
        end else begin
            pend <= i_valid;
            if (i_valid) begin
                sign_i_new <= i_corr.i[7];
                sign_q_new <= i_corr.q[7];
            end
            if (pend) begin
                sign_i_prev <= sign_i_new;
                sign_q_prev <= sign_q_new;
                if (i_changed) begin
                    run_i <= 8'd1;
                end else if (run_i != track_pkg::RUN_MAX) begin
                    run_i <= run_i + 8'd1;
                end
                if (q_changed) begin
                    run_q <= 8'd1;
                end else if (run_q != track_pkg::RUN_MAX) begin
                    run_q <= run_q + 8'd1;
                end
            end
        end
    end

    // Runs are summed in alternating I and Q turns; only I turns are counted.
    always_ff @(posedge clk) begin
        if (rst_in) begin
            turn_q  <= 1'b0;
            sum     <= '0;
            turns   <= '0;
            o_est   <= '0;
            o_valid <= 1'b0;
        end else if (turns == TURNS_PER_EST) begin
            o_est   <= sum[EST_LOG2 +: 8];
            o_valid <= 1'b1;
            sum     <= '0;
            turns   <= '0;
        end else begin
            o_valid <= 1'b0;
            if (pend) begin
                if (q_changed && turn_q) begin
                    sum    <= sum + ACC_W'(run_q);
                    turn_q <= 1'b0;
                end else if (i_changed && !turn_q) begin
                    sum    <= sum + ACC_W'(run_i);
                    turn_q <= 1'b1;
                    turns  <= turns + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/track_pkg.sv */
`default_nettype none

package track_pkg;

    // Signed correlation result of one window.
    typedef logic signed [7:0] corr_t;

    // Number of consecutive windows with the same sign.
    typedef logic [7:0] run_t;

    // Averaged run length.
    typedef logic [7:0] est_t;

    localparam corr_t CORR_MAX = 8'sd127;
    localparam corr_t CORR_MIN = -8'sd128;
    localparam run_t RUN_MAX = 8'd255;

    typedef struct packed {
        corr_t i;
        corr_t q;
    } corr_pair_t;

    typedef enum logic {
        ST_CLEAR,
        ST_INTEGRATE
    } dump_state_t;

endpackage

`default_nettype wire
